//--- hdl/mips_mem_pkg.sv
`default_nettype none

package mips_mem_pkg;

  ////////////////////////////////////////////////////////////
  // Storage geometry
  ////////////////////////////////////////////////////////////

  localparam int BYTE_W    = 8;   // Bits per byte lane
  localparam int NUM_LANES = 4;   // Byte lanes in one word

  // One 32-bit memory word
  typedef logic [NUM_LANES*BYTE_W-1:0] word_t;

  // Byte-write enable, bit n writes lane n
  typedef logic [NUM_LANES-1:0] byte_en_t;

  ////////////////////////////////////////////////////////////
  // Soft-reset clear sequencer
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    IDLE     = 2'd0,  // No clear in progress
    CLEARING = 2'd1,  // Walking the word counter through the array
    DONE     = 2'd2   // Every word restored, ack held
  } clr_state_e;

endpackage

`default_nettype wire

//--- hdl/mips_ls_pkg.sv
`default_nettype none

package mips_ls_pkg;

  ////////////////////////////////////////////////////////////
  // Load/store access encoding
  ////////////////////////////////////////////////////////////

  // Access size, matches the MIPS lb/lh/lw split
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } mem_size_e;

  // Byte offset inside a word, low two address bits
  typedef logic [1:0] lane_t;

  // Load-control record as it travels down the decoder pipe
  // Layout is {lane, size, unsigned, misaligned}
  localparam int LD_CTRL_W = $bits(lane_t) + $bits(mem_size_e) + 2;

endpackage

`default_nettype wire

//--- hdl/mips_access_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module mips_access_decoder #(
  parameter int DEPTH   = 256,  // Words in the data memory
  parameter int OUT_REG = 1     // 1 adds the memory output register
) (
  input  wire                                  i_clk,
  input  wire                                  i_rsta,
  input  wire                                  i_mem_read,     // Load strobe
  input  wire                                  i_mem_write,    // Store strobe, wins over load
  input  mips_ls_pkg::mem_size_e               i_size,
  input  wire                                  i_unsigned,     // Zero-extend loads
  input  wire [$clog2(DEPTH)+1:0]              i_addr,         // Byte address
  input  mips_mem_pkg::word_t                  i_wdata,
  output logic                                 o_en,
  output mips_mem_pkg::byte_en_t               o_we,
  output logic [$clog2(DEPTH)-1:0]             o_word_addr,
  output mips_mem_pkg::word_t                  o_wdata_lanes,
  output mips_ls_pkg::lane_t                   o_ld_lane,
  output mips_ls_pkg::mem_size_e               o_ld_size,
  output logic                                 o_ld_unsigned,
  output logic                                 o_ld_misaligned
);

  import mips_mem_pkg::*;
  import mips_ls_pkg::*;

  localparam int ADDR_W = $clog2(DEPTH) + 2;  // Byte address width
  localparam int LAT    = 1 + OUT_REG;        // Read latency in cycles

  lane_t    lane;         // Byte offset of the request
  logic     aligned;      // Offset legal for the size
  logic     any_req;      // Some strobe is up
  logic     misaligned;
  logic     is_store;
  logic     is_load;
  byte_en_t lane_mask;    // Lanes covered by the access

  logic [LD_CTRL_W-1:0]          ld_ctrl;   // Record entering the pipe
  logic [LAT-1:0][LD_CTRL_W-1:0] ld_pipe;   // One stage per latency cycle
  logic [LD_CTRL_W-1:0]          ld_out;    // Last stage

  ////////////////////////////////////////////////////////////
  // Alignment and lane decode
  ////////////////////////////////////////////////////////////

  assign lane    = i_addr[1:0];
  assign any_req = i_mem_read | i_mem_write;

  always_comb begin
    case (i_size)
      SIZE_BYTE: aligned = 1'b1;          // Any offset
      SIZE_HALF: aligned = ~lane[0];      // Offset 0 or 2
      SIZE_WORD: aligned = (lane == 2'd0);
      default:   aligned = 1'b0;          // Unused encoding never aligns
    endcase
  end

  always_comb begin
    case (i_size)
      SIZE_BYTE: lane_mask = byte_en_t'(4'b0001 << lane);
      SIZE_HALF: lane_mask = byte_en_t'(4'b0011 << lane);
      default:   lane_mask = 4'b1111;
    endcase
  end

  assign misaligned = any_req & ~aligned;
  assign is_store   = i_mem_write & aligned;                  // Store wins a collision
  assign is_load    = i_mem_read & ~i_mem_write & aligned;

  ////////////////////////////////////////////////////////////
  // Memory request
  ////////////////////////////////////////////////////////////

  assign o_en        = is_store | is_load;                    // Misaligned drives nothing
  assign o_we        = is_store ? lane_mask : '0;             // Loads carry no enables
  assign o_word_addr = i_addr[ADDR_W-1:2];

  // Replicate the store data so every lane holds a copy,
  // the byte enables then pick the lanes that are written
  always_comb begin
    case (i_size)
      SIZE_BYTE: o_wdata_lanes = {4{i_wdata[7:0]}};
      SIZE_HALF: o_wdata_lanes = {2{i_wdata[15:0]}};
      default:   o_wdata_lanes = i_wdata;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Load-control delay line
  ////////////////////////////////////////////////////////////

  assign ld_ctrl = {lane, i_size, i_unsigned, misaligned};

  always_ff @(posedge i_clk) begin
    if (i_rsta) begin
      ld_pipe <= '0;                                          // Flush, no stale flags
    end else begin
      ld_pipe[0] <= ld_ctrl;
      for (int s = 1; s < LAT; s++) begin
        ld_pipe[s] <= ld_pipe[s-1];                           // Age by one cycle
      end
    end
  end

  assign ld_out = ld_pipe[LAT-1];

  // Unpack in the same order the record was built
  assign o_ld_lane       = lane_t'(ld_out[5:4]);
  assign o_ld_size       = mem_size_e'(ld_out[3:2]);
  assign o_ld_unsigned   = ld_out[1];
  assign o_ld_misaligned = ld_out[0];                         // Loads and stores alike

endmodule

`default_nettype wire

//--- hdl/mips_data_memory.sv
`timescale 1ns/1ps
`default_nettype none

module mips_data_memory #(
  parameter int DEPTH   = 256,  // Words in the array
  parameter int OUT_REG = 1     // 1 adds the output register
) (
  input  wire                          i_clk,
  input  wire                          i_rsta,
  input  wire                          i_en,           // Access enable
  input  mips_mem_pkg::byte_en_t       i_we,           // Zero means load
  input  wire [$clog2(DEPTH)-1:0]      i_word_addr,
  input  mips_mem_pkg::word_t          i_wdata,        // Lane-aligned store data
  input  wire                          i_soft_reset,   // Clear request level
  output mips_mem_pkg::word_t          o_rdata_raw,
  output logic                         o_rd_valid,     // Accepted load, delayed
  output logic                         o_soft_reset_ack
);

  import mips_mem_pkg::*;

  localparam int WORD_AW = $clog2(DEPTH);   // Word address width
  localparam int LAT     = 1 + OUT_REG;     // Read latency in cycles

  localparam logic [WORD_AW-1:0] LAST_WORD = WORD_AW'(DEPTH - 1);

  word_t mem [DEPTH];                       // Storage array
  word_t rd_q;                              // Read-first data register

  clr_state_e           clr_state;
  logic [WORD_AW-1:0]   clr_cnt;            // Next word to clear
  logic                 clr_we;             // Sequencer owns the write port
  logic                 req_ok;             // Request accepted this cycle

  byte_en_t             wr_be;              // Muxed write port
  logic [WORD_AW-1:0]   wr_addr;
  word_t                wr_data;

  logic [LAT-1:0]       vld_pipe;           // Read-valid shift register

  // Contents start as the word index
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = word_t'(i);
    end
  end

  ////////////////////////////////////////////////////////////
  // Write port arbitration
  ////////////////////////////////////////////////////////////

  assign req_ok = i_en & ~i_soft_reset;                     // Requests ignored during clear
  assign clr_we = i_soft_reset & (clr_state != DONE);

  assign wr_be   = clr_we ? '1 : (req_ok ? i_we : '0);
  assign wr_addr = clr_we ? clr_cnt : i_word_addr;
  assign wr_data = clr_we ? word_t'(clr_cnt) : i_wdata;     // Clear restores index

  // Byte-write array, each lane under its own enable
  always @(posedge i_clk) begin
    for (int l = 0; l < NUM_LANES; l++) begin
      if (wr_be[l]) begin
        mem[wr_addr][l*BYTE_W +: BYTE_W] <= wr_data[l*BYTE_W +: BYTE_W];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////////////

  // Read-first, a store returns the old word
  always_ff @(posedge i_clk) begin
    if (req_ok) begin
      rd_q <= mem[i_word_addr];
    end
  end

  generate
    if (OUT_REG != 0) begin : g_out_reg
      word_t out_q;                                         // Second stage for timing
      always_ff @(posedge i_clk) begin
        if (i_rsta) begin
          out_q <= '0;
        end else begin
          out_q <= rd_q;
        end
      end
      assign o_rdata_raw = out_q;
    end else begin : g_no_out_reg
      assign o_rdata_raw = rd_q;                            // Single-cycle read
    end
  endgenerate

  // Valid follows the data through the same number of stages
  always_ff @(posedge i_clk) begin
    if (i_rsta) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe[0] <= req_ok & (i_we == '0);                 // Loads only
      for (int s = 1; s < LAT; s++) begin
        vld_pipe[s] <= vld_pipe[s-1];
      end
    end
  end

  assign o_rd_valid = vld_pipe[LAT-1];

  ////////////////////////////////////////////////////////////
  // Soft-reset clear sequencer
  ////////////////////////////////////////////////////////////

  // Word k is written at the k-th edge after the request is seen
  always_ff @(posedge i_clk) begin
    if (i_rsta) begin
      clr_state <= IDLE;
      clr_cnt   <= '0;
    end else if (!i_soft_reset) begin
      clr_state <= IDLE;                                    // Drop aborts, partial clear kept
      clr_cnt   <= '0;
    end else begin
      case (clr_state)
        IDLE, CLEARING: begin
          if (clr_cnt == LAST_WORD) begin
            clr_state <= DONE;
          end else begin
            clr_state <= CLEARING;
            clr_cnt   <= clr_cnt + 1'b1;
          end
        end
        default: clr_state <= DONE;                         // Hold until request drops
      endcase
    end
  end

  // Ack only while the request is still held
  assign o_soft_reset_ack = (clr_state == DONE) & i_soft_reset;

endmodule

`default_nettype wire

//--- hdl/mips_load_formatter.sv
`timescale 1ns/1ps
`default_nettype none

module mips_load_formatter (
  input  wire                        i_clk,
  input  wire                        i_rsta,
  input  mips_mem_pkg::word_t        i_rdata_raw,      // Whole word from memory
  input  wire                        i_rd_valid,
  input  mips_ls_pkg::lane_t         i_ld_lane,
  input  mips_ls_pkg::mem_size_e     i_ld_size,
  input  wire                        i_ld_unsigned,
  input  wire                        i_ld_misaligned,
  output mips_mem_pkg::word_t        o_rdata,
  output logic                       o_rvalid,
  output logic                       o_misaligned
);

  import mips_mem_pkg::*;
  import mips_ls_pkg::*;

  word_t shifted;     // Addressed lane moved to bit 0
  word_t formatted;   // Extended result

  ////////////////////////////////////////////////////////////
  // Lane select and extension
  ////////////////////////////////////////////////////////////

  assign shifted = i_rdata_raw >> {i_ld_lane, 3'b000};  // Lane times eight

  always_comb begin
    case (i_ld_size)
      SIZE_BYTE: begin
        if (i_ld_unsigned) begin
          formatted = {24'd0, shifted[7:0]};
        end else begin
          formatted = {{24{shifted[7]}}, shifted[7:0]};    // lb sign bit
        end
      end
      SIZE_HALF: begin
        if (i_ld_unsigned) begin
          formatted = {16'd0, shifted[15:0]};
        end else begin
          formatted = {{16{shifted[15]}}, shifted[15:0]};  // lh sign bit
        end
      end
      default: formatted = i_rdata_raw;                    // Word passes through
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Result register
  ////////////////////////////////////////////////////////////

  // Data only moves on a valid load
  always_ff @(posedge i_clk) begin
    if (i_rd_valid) begin
      o_rdata <= formatted;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rsta) begin
      o_rvalid     <= 1'b0;
      o_misaligned <= 1'b0;
    end else begin
      o_rvalid     <= i_rd_valid;       // One-cycle strobe
      o_misaligned <= i_ld_misaligned;  // Pulse, never with rvalid
    end
  end

endmodule

`default_nettype wire

//--- hdl/mips_mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mips_mem_stage #(
  parameter int DEPTH   = 256,  // Words of data memory
  parameter int OUT_REG = 1     // Read latency is 1 + OUT_REG
) (
  input  wire                          i_clk,
  input  wire                          i_rsta,
  input  wire                          i_mem_read,
  input  wire                          i_mem_write,
  input  mips_ls_pkg::mem_size_e       i_size,
  input  wire                          i_unsigned,
  input  wire [$clog2(DEPTH)+1:0]      i_addr,
  input  mips_mem_pkg::word_t          i_wdata,
  input  wire                          i_soft_reset,
  output mips_mem_pkg::word_t          o_rdata,
  output logic                         o_rvalid,
  output logic                         o_misaligned,
  output logic                         o_soft_reset_ack
);

  import mips_mem_pkg::*;
  import mips_ls_pkg::*;

  ////////////////////////////////////////////////////////////
  // Decoder to memory
  ////////////////////////////////////////////////////////////
  logic                     mem_en;
  byte_en_t                 mem_we;
  logic [$clog2(DEPTH)-1:0] mem_word_addr;
  word_t                    mem_wdata;

  // Decoder to formatter, load-control record
  lane_t      ld_lane;
  mem_size_e  ld_size;
  logic       ld_unsigned;
  logic       ld_misaligned;

  // Memory to formatter
  word_t      rdata_raw;
  logic       rd_valid;

  mips_access_decoder #(
    .DEPTH   (DEPTH),
    .OUT_REG (OUT_REG)
  ) u_decoder (
    .i_clk           (i_clk),
    .i_rsta          (i_rsta),
    .i_mem_read      (i_mem_read),
    .i_mem_write     (i_mem_write),
    .i_size          (i_size),
    .i_unsigned      (i_unsigned),
    .i_addr          (i_addr),
    .i_wdata         (i_wdata),
    .o_en            (mem_en),
    .o_we            (mem_we),
    .o_word_addr     (mem_word_addr),
    .o_wdata_lanes   (mem_wdata),
    .o_ld_lane       (ld_lane),
    .o_ld_size       (ld_size),
    .o_ld_unsigned   (ld_unsigned),
    .o_ld_misaligned (ld_misaligned)
  );

  mips_data_memory #(
    .DEPTH   (DEPTH),
    .OUT_REG (OUT_REG)
  ) u_memory (
    .i_clk            (i_clk),
    .i_rsta           (i_rsta),
    .i_en             (mem_en),
    .i_we             (mem_we),
    .i_word_addr      (mem_word_addr),
    .i_wdata          (mem_wdata),
    .i_soft_reset     (i_soft_reset),
    .o_rdata_raw      (rdata_raw),
    .o_rd_valid       (rd_valid),
    .o_soft_reset_ack (o_soft_reset_ack)
  );

  // Final register of the read path
  mips_load_formatter u_formatter (
    .i_clk           (i_clk),
    .i_rsta          (i_rsta),
    .i_rdata_raw     (rdata_raw),
    .i_rd_valid      (rd_valid),
    .i_ld_lane       (ld_lane),
    .i_ld_size       (ld_size),
    .i_ld_unsigned   (ld_unsigned),
    .i_ld_misaligned (ld_misaligned),
    .o_rdata         (o_rdata),
    .o_rvalid        (o_rvalid),
    .o_misaligned    (o_misaligned)
  );

endmodule

`default_nettype wire

//--- sim/mips_mem_stage_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mips_mem_stage_checker (
  input wire i_clk,
  input wire i_rsta,
  input wire i_soft_reset,
  input wire i_rvalid,
  input wire i_misaligned,
  input wire i_soft_reset_ack
);

  int assert_fails = 0;   // Failed assertion count

  ////////////////////////////////////////////////////////////
  // Result strobes
  ////////////////////////////////////////////////////////////

  // A request never both loads and flags
  a_strobe_excl: assert property (@(posedge i_clk) disable iff (i_rsta)
    !(i_rvalid && i_misaligned))
    else begin
      assert_fails++;
      $error("o_rvalid and o_misaligned high in the same cycle");
    end

  // Ack is qualified by the held request
  a_ack_needs_req: assert property (@(posedge i_clk) disable iff (i_rsta)
    !i_soft_reset |-> !i_soft_reset_ack)
    else begin
      assert_fails++;
      $error("o_soft_reset_ack high without i_soft_reset");
    end

  // Everything quiet right after reset
  a_reset_quiet: assert property (@(posedge i_clk)
    i_rsta |=> (!i_rvalid && !i_misaligned && !i_soft_reset_ack))
    else begin
      assert_fails++;
      $error("Output strobe high in the cycle after i_rsta");
    end

endmodule

bind mips_mem_stage mips_mem_stage_checker u_checker (
  .i_clk            (i_clk),
  .i_rsta           (i_rsta),
  .i_soft_reset     (i_soft_reset),
  .i_rvalid         (o_rvalid),
  .i_misaligned     (o_misaligned),
  .i_soft_reset_ack (o_soft_reset_ack)
);

`default_nettype wire

//--- sim/tb_mips_mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_mem_stage;

  import mips_ls_pkg::*;

  localparam int DEPTH   = 256;
  localparam int OUT_REG = 1;
  localparam int LAT     = 1 + OUT_REG;        // Read latency in edges
  localparam int WORD_AW = $clog2(DEPTH);
  localparam int ADDR_W  = WORD_AW + 2;

  // Test sizes, also used for the run limit
  localparam int N_INIT = 8;
  localparam int N_PART = 6;
  localparam int N_B2B  = 6;
  localparam int N_SR   = 6;
  localparam int ACC    = LAT + 4;             // Worst cycles per access incl. drain
  localparam int N_ACC  = N_INIT + 3*N_PART + 13 + N_B2B + 4 + 8 + 3*N_SR;
  localparam int TEST_CYCLES = ACC*N_ACC + DEPTH + 8 + 4;
  localparam int LIMIT  = 2*TEST_CYCLES + DEPTH;

  logic              i_clk;
  logic              i_rsta;
  logic              i_mem_read;
  logic              i_mem_write;
  mem_size_e         i_size;
  logic              i_unsigned;
  logic [ADDR_W-1:0] i_addr;
  logic [31:0]       i_wdata;
  logic              i_soft_reset;
  logic [31:0]       o_rdata;
  logic              o_rvalid;
  logic              o_misaligned;
  logic              o_soft_reset_ack;

  logic [31:0] ref_mem [DEPTH];              // Reference memory model
  integer      seed = 32'h54cf_4b0f;
  int          cyc = 0;                      // Advances on every falling edge
  int          errors = 0;
  int          n_checks = 0;

  // Expected results, oldest first
  int          due_q [$];
  bit          mis_q [$];
  logic [31:0] data_q [$];
  string       name_q [$];

  mips_mem_stage #(
    .DEPTH   (DEPTH),
    .OUT_REG (OUT_REG)
  ) UUT (
    .i_clk            (i_clk),
    .i_rsta           (i_rsta),
    .i_mem_read       (i_mem_read),
    .i_mem_write      (i_mem_write),
    .i_size           (i_size),
    .i_unsigned       (i_unsigned),
    .i_addr           (i_addr),
    .i_wdata          (i_wdata),
    .i_soft_reset     (i_soft_reset),
    .o_rdata          (o_rdata),
    .o_rvalid         (o_rvalid),
    .o_misaligned     (o_misaligned),
    .o_soft_reset_ack (o_soft_reset_ack)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;               // 4 ns period
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (act !== exp) begin
      errors++;
      $display("Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  function automatic bit is_aligned(input mem_size_e size, input lane_t lane);
    case (size)
      SIZE_BYTE: return 1'b1;
      SIZE_HALF: return (lane == 2'd0) || (lane == 2'd2);
      default:   return lane == 2'd0;
    endcase
  endfunction

  // Load result as the ISA defines it: pick the lanes, then extend
  function automatic logic [31:0] expect_load(input logic [31:0] word, input lane_t lane,
                                              input mem_size_e size, input bit uns);
    logic [7:0]  b;
    logic [15:0] h;
    case (size)
      SIZE_BYTE: begin
        b = word[8*lane +: 8];
        return uns ? {24'h0, b} : {{24{b[7]}}, b};
      end
      SIZE_HALF: begin
        h = lane[1] ? word[31:16] : word[15:0];
        return uns ? {16'h0, h} : {{16{h[15]}}, h};
      end
      default: return word;
    endcase
  endfunction

  function automatic logic [WORD_AW-1:0] rand_word();
    logic [31:0] r;
    r = $random(seed);
    return r[WORD_AW-1:0];
  endfunction

  // Drive one request for one cycle and update the model
  task automatic access(input string name, input bit rd, input bit wr, input mem_size_e size,
                        input bit uns, input logic [ADDR_W-1:0] addr, input logic [31:0] wdata);
    lane_t              lane;
    logic [WORD_AW-1:0] wa;
    @(posedge i_clk);
    i_mem_read  <= rd;
    i_mem_write <= wr;
    i_size      <= size;
    i_unsigned  <= uns;
    i_addr      <= addr;
    i_wdata     <= wdata;
    lane = addr[1:0];
    wa   = addr[ADDR_W-1:2];
    if (!is_aligned(size, lane)) begin
      due_q.push_back(cyc + LAT + 2);        // Sampled next edge, seen LAT edges on
      mis_q.push_back(1'b1);
      data_q.push_back('0);
      name_q.push_back(name);
    end else if (wr) begin
      case (size)
        SIZE_BYTE: ref_mem[wa][8*lane +: 8] = wdata[7:0];
        SIZE_HALF: ref_mem[wa][8*lane +: 16] = wdata[15:0];
        default:   ref_mem[wa] = wdata;
      endcase
    end else if (rd) begin
      due_q.push_back(cyc + LAT + 2);
      mis_q.push_back(1'b0);
      data_q.push_back(expect_load(ref_mem[wa], lane, size, uns));
      name_q.push_back(name);
    end
  endtask

  task automatic load(input string name, input mem_size_e size, input bit uns,
                      input logic [ADDR_W-1:0] addr);
    access(name, 1'b1, 1'b0, size, uns, addr, '0);
  endtask

  task automatic store(input string name, input mem_size_e size,
                       input logic [ADDR_W-1:0] addr, input logic [31:0] data);
    access(name, 1'b0, 1'b1, size, 1'b0, addr, data);
  endtask

  task automatic end_requests();
    @(posedge i_clk);
    i_mem_read  <= 1'b0;
    i_mem_write <= 1'b0;
  endtask

  // Bus idle until every expected result has come back
  task automatic wait_results();
    while (due_q.size() > 0) begin
      @(posedge i_clk);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Result monitor and run limit
  ////////////////////////////////////////////////////////////

  always @(negedge i_clk) begin : monitor
    string name;
    cyc = cyc + 1;
    if (cyc > LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", LIMIT);
      $display("Simulation failed");
      $finish;
    end else if (!i_rsta) begin
      if (due_q.size() > 0 && due_q[0] == cyc) begin
        name = name_q.pop_front();
        void'(due_q.pop_front());
        check({name, " rvalid"}, !mis_q[0], o_rvalid);
        check({name, " misaligned"}, mis_q[0], o_misaligned);
        if (!mis_q[0]) begin
          check({name, " rdata"}, data_q[0], o_rdata);
        end
        void'(mis_q.pop_front());
        void'(data_q.pop_front());
      end else begin
        check("idle cycle rvalid", 1'b0, o_rvalid);       // Nothing due now
        check("idle cycle misaligned", 1'b0, o_misaligned);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic initial_contents();
    for (int i = 0; i < N_INIT; i++) begin
      load("initial_contents word", SIZE_WORD, 1'b0, {rand_word(), 2'b00});
      end_requests();
      wait_results();
    end
  endtask

  task automatic partial_stores();
    logic [WORD_AW-1:0] wa;
    logic [31:0]        d;
    for (int i = 0; i < N_PART; i++) begin
      wa = rand_word();
      d  = $random(seed);
      store("partial_stores byte", SIZE_BYTE, {wa, d[1:0]}, d);
      store("partial_stores half", SIZE_HALF, {wa, d[9], 1'b0}, {d[15:0], d[31:16]});
      load("partial_stores word", SIZE_WORD, 1'b0, {wa, 2'b00});
    end
    end_requests();
    wait_results();
  endtask

  task automatic subword_loads();
    logic [WORD_AW-1:0] wa;
    wa = rand_word();
    store("subword_loads setup", SIZE_WORD, {wa, 2'b00}, 32'h9C7F_E281);  // Mixed sign bytes
    for (int l = 0; l < 4; l++) begin
      load("subword_loads lb", SIZE_BYTE, 1'b0, {wa, l[1:0]});
      load("subword_loads lbu", SIZE_BYTE, 1'b1, {wa, l[1:0]});
    end
    for (int l = 0; l < 4; l += 2) begin
      load("subword_loads lh", SIZE_HALF, 1'b0, {wa, l[1:0]});
      load("subword_loads lhu", SIZE_HALF, 1'b1, {wa, l[1:0]});
    end
    end_requests();
    wait_results();
  endtask

  task automatic back_to_back();
    logic [WORD_AW-1:0] wa;
    for (int i = 0; i < N_B2B; i++) begin
      load("back_to_back word", SIZE_WORD, 1'b0, {rand_word(), 2'b00});
    end
    wa = rand_word();
    store("back_to_back store", SIZE_WORD, {wa, 2'b00}, $random(seed));
    load("back_to_back after store", SIZE_WORD, 1'b0, {wa, 2'b00});   // Must see new word
    store("back_to_back byte", SIZE_BYTE, {wa, 2'd3}, 32'h0000_00A5);
    load("back_to_back after byte", SIZE_BYTE, 1'b0, {wa, 2'd3});
    end_requests();
    wait_results();
  endtask

  task automatic misaligned_requests();
    logic [WORD_AW-1:0] wa;
    wa = rand_word();
    load("misaligned lh off1", SIZE_HALF, 1'b0, {wa, 2'd1});
    load("misaligned lh off3", SIZE_HALF, 1'b1, {wa, 2'd3});
    load("misaligned lw off1", SIZE_WORD, 1'b0, {wa, 2'd1});
    load("misaligned lw off2", SIZE_WORD, 1'b0, {wa, 2'd2});
    load("misaligned lw off3", SIZE_WORD, 1'b0, {wa, 2'd3});
    store("misaligned sh off3", SIZE_HALF, {wa, 2'd3}, 32'hFFFF_FFFF);
    store("misaligned sw off2", SIZE_WORD, {wa, 2'd2}, 32'hDEAD_BEEF);
    end_requests();
    wait_results();
    load("misaligned unchanged", SIZE_WORD, 1'b0, {wa, 2'b00});
    end_requests();
    wait_results();
  endtask

  task automatic soft_reset_clear();
    logic [WORD_AW-1:0] sr_words [N_SR];
    int                 n;
    for (int i = 0; i < N_SR; i++) begin
      sr_words[i] = rand_word();
      store("soft_reset_clear store", SIZE_WORD, {sr_words[i], 2'b00}, $random(seed));
    end
    end_requests();
    wait_results();
    @(posedge i_clk);
    i_soft_reset <= 1'b1;
    @(negedge i_clk);
    n = 0;
    while (!o_soft_reset_ack && n < DEPTH + 8) begin
      @(negedge i_clk);
      n++;
    end
    check("soft_reset_clear ack delay", DEPTH, n);       // One word per cycle
    repeat (3) begin
      @(negedge i_clk);
      check("soft_reset_clear ack held", 1'b1, o_soft_reset_ack);
    end
    @(posedge i_clk);
    i_soft_reset <= 1'b0;
    @(negedge i_clk);
    check("soft_reset_clear ack drop", 1'b0, o_soft_reset_ack);
    for (int i = 0; i < DEPTH; i++) begin
      ref_mem[i] = i;                                    // Clear restores index values
    end
    for (int i = 0; i < N_SR; i++) begin
      load("soft_reset_clear stored word", SIZE_WORD, 1'b0, {sr_words[i], 2'b00});
      load("soft_reset_clear random word", SIZE_WORD, 1'b0, {rand_word(), 2'b00});
    end
    end_requests();
    wait_results();
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    i_rsta       = 1'b1;
    i_mem_read   = 1'b0;
    i_mem_write  = 1'b0;
    i_size       = SIZE_WORD;
    i_unsigned   = 1'b0;
    i_addr       = '0;
    i_wdata      = '0;
    i_soft_reset = 1'b0;
    for (int i = 0; i < DEPTH; i++) begin
      ref_mem[i] = i;                                    // Power-up contents
    end
    repeat (4) @(posedge i_clk);
    i_rsta <= 1'b0;

    initial_contents();
    partial_stores();
    subword_loads();
    back_to_back();
    misaligned_requests();
    soft_reset_clear();

    check("bound assertion failures", 0, UUT.u_checker.assert_fails);
    $display("Checks: %0d, errors: %0d", n_checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
hdl/mips_mem_pkg.sv
hdl/mips_ls_pkg.sv
hdl/mips_access_decoder.sv
hdl/mips_data_memory.sv
hdl/mips_load_formatter.sv
hdl/mips_mem_stage.sv
sim/mips_mem_stage_checker.sv
sim/tb_mips_mem_stage.sv
